// File: source/cpu_addr_pkg.sv
package cpu_addr_pkg;

	// ====================
	// Core address space
	// ====================

	// Byte addresses on the fetch side are one machine word wide
	localparam int unsigned addr_w = 32;

	// A fetch address points at any byte
	// Only the line number part matters to the cache
	typedef logic [addr_w-1:0] fetch_addr_t;

endpackage

// File: source/icache_pkg.sv
package icache_pkg;

	// ====================
	// Line geometry
	// ====================

	// One cache line holds eight 32-bit words
	localparam int unsigned line_bytes = 32;
	localparam int unsigned offset_bits = 5;

	// Lowest bit of the line number picks the even or the odd bank
	localparam int unsigned bank_sel_bit = 5;

	// ====================
	// Bank geometry
	// ====================

	// Each bank is 2-way set-associative with 32 sets
	localparam int unsigned sets = 32;
	localparam int unsigned index_bits = 5;
	localparam int unsigned ways = 2;

	// Tag is everything above the index and the bank select bit
	localparam int unsigned tag_bits = 21;

	// ====================
	// Types
	// ====================

	typedef logic [tag_bits-1:0] tag_t;
	typedef logic [index_bits-1:0] index_t;
	typedef logic [$clog2(ways)-1:0] way_t;

	// Line payload, 8 words packed low word first
	typedef logic [line_bytes*8-1:0] line_data_t;

	// Byte address with the offset dropped
	typedef logic [cpu_addr_pkg::addr_w-offset_bits-1:0] line_num_t;

endpackage

// File: source/line_ram.sv
`timescale 1ns/100ps

module line_ram #(
	parameter type payload_t = icache_pkg::line_data_t,
	parameter int unsigned depth = icache_pkg::sets
) (
	input logic clk,

	// Write port
	input logic wr_i,
	input logic [$clog2(depth)-1:0] wr_addr_i,
	input payload_t wr_data_i,

	// Read port
	input logic [$clog2(depth)-1:0] rd_addr_i,
	output payload_t rd_data_o
);

	// ====================
	// Storage
	// ====================

	// Plain array so synthesis can map it to block or distributed RAM
	payload_t mem [depth];

	// Write happens at the edge when wr_i is high
	always_ff @(posedge clk) begin
		if (wr_i) begin
			mem[wr_addr_i] <= wr_data_i;
		end
	end

	// ====================
	// Registered read
	// ====================

	// The read samples the array before this edge's write lands,
	// so a same-address collision returns the old word
	always_ff @(posedge clk) begin
		rd_data_o <= mem[rd_addr_i];
	end

endmodule

// File: source/icache_bank.sv
`timescale 1ns/100ps

module icache_bank (
	input logic clk,
	input logic rst,

	// Fetch request, looked up at the edge
	input icache_pkg::index_t req_index_i,
	input icache_pkg::tag_t req_tag_i,

	// Refill of one line into a chosen way
	input logic wr_i,
	input icache_pkg::index_t wr_index_i,
	input icache_pkg::tag_t wr_tag_i,
	input icache_pkg::way_t wr_way_i,
	input icache_pkg::line_data_t wr_data_i,

	// Invalidation
	input logic inv_line_i,
	input icache_pkg::index_t inv_index_i,
	input logic inv_all_i,

	// Snoop from another bus master
	input logic snoop_v_i,
	input icache_pkg::index_t snoop_index_i,
	input icache_pkg::tag_t snoop_tag_i,

	// Lookup result, one cycle after the request
	output logic hit_o,
	output icache_pkg::line_data_t data_o
);

	localparam int unsigned ways = icache_pkg::ways;
	localparam int unsigned sets = icache_pkg::sets;

	// One valid bit per set and way
	logic [sets-1:0] valid_q [ways];

	// Registered fetch request for the compare stage
	icache_pkg::tag_t req_tag_q;
	icache_pkg::index_t req_index_q;

	// A refill landing on the looked-up entry at the request edge
	logic [ways-1:0] refill_hazard_q;

	// Registered snoop for the second snoop edge
	logic snoop_v_q;
	icache_pkg::index_t snoop_index_q;
	icache_pkg::tag_t snoop_tag_q;

	// RAM read outputs per way
	icache_pkg::line_data_t data_rd [ways];
	icache_pkg::tag_t fetch_tag_rd [ways];
	icache_pkg::tag_t snoop_tag_rd [ways];

	logic [ways-1:0] way_hit;
	logic [ways-1:0] snoop_hit;

	// ====================
	// Storage per way
	// ====================

	for (genvar w = 0; w < ways; w++) begin : g_way
		logic way_wr;

		assign way_wr = wr_i && (wr_way_i == icache_pkg::way_t'(w));

		line_ram #(.payload_t(icache_pkg::line_data_t), .depth(sets)) data_ram_inst (
			.clk(clk),
			.wr_i(way_wr),
			.wr_addr_i(wr_index_i),
			.wr_data_i(wr_data_i),
			.rd_addr_i(req_index_i),
			.rd_data_o(data_rd[w])
		);

		line_ram #(.payload_t(icache_pkg::tag_t), .depth(sets)) fetch_tag_ram_inst (
			.clk(clk),
			.wr_i(way_wr),
			.wr_addr_i(wr_index_i),
			.wr_data_i(wr_tag_i),
			.rd_addr_i(req_index_i),
			.rd_data_o(fetch_tag_rd[w])
		);

		// Duplicate tags give snoops their own read port
		line_ram #(.payload_t(icache_pkg::tag_t), .depth(sets)) snoop_tag_ram_inst (
			.clk(clk),
			.wr_i(way_wr),
			.wr_addr_i(wr_index_i),
			.wr_data_i(wr_tag_i),
			.rd_addr_i(snoop_index_i),
			.rd_data_o(snoop_tag_rd[w])
		);

		// The RAM hands back the old line when a refill hits the same entry
		// at the request edge, so that way is kept from hitting
		assign way_hit[w] = valid_q[w][req_index_q] && (fetch_tag_rd[w] == req_tag_q) &&
			!refill_hazard_q[w];
		assign snoop_hit[w] = snoop_v_q && (snoop_tag_rd[w] == snoop_tag_q);
	end

	// ====================
	// Request and snoop registers
	// ====================

	always_ff @(posedge clk) begin
		req_tag_q <= req_tag_i;
		req_index_q <= req_index_i;
		snoop_index_q <= snoop_index_i;
		snoop_tag_q <= snoop_tag_i;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			snoop_v_q <= 1'b0;
			refill_hazard_q <= '0;
		end else begin
			snoop_v_q <= snoop_v_i;
			for (int w = 0; w < ways; w++) begin
				refill_hazard_q[w] <= wr_i && (wr_way_i == icache_pkg::way_t'(w)) &&
					(wr_index_i == req_index_i);
			end
		end
	end

	// ====================
	// Valid bits
	// ====================

	// Later statements win, which gives refill over invalidation
	// and snoop clear over refill
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < ways; w++) begin
				valid_q[w] <= '0;
			end
		end else begin
			for (int w = 0; w < ways; w++) begin
				if (inv_all_i) begin
					valid_q[w] <= '0;
				end
				if (inv_line_i) begin
					valid_q[w][inv_index_i] <= 1'b0;
				end
				if (wr_i && (wr_way_i == icache_pkg::way_t'(w))) begin
					valid_q[w][wr_index_i] <= 1'b1;
				end
				if (snoop_hit[w]) begin
					valid_q[w][snoop_index_q] <= 1'b0;
				end
			end
		end
	end

	// ====================
	// Hit and way select
	// ====================

	always_comb begin
		data_o = data_rd[0];
		for (int w = 1; w < ways; w++) begin
			if (way_hit[w]) begin
				data_o = data_rd[w];
			end
		end
	end

	assign hit_o = |way_hit;

	// A line is only ever refilled into one way, so tags never repeat in a set
	a_one_way_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(way_hit));

	a_wr_way_known: assert property (@(posedge clk) disable iff (rst)
		wr_i |-> !$isunknown(wr_way_i));

endmodule

// File: source/line_pair_merge.sv
`timescale 1ns/100ps

module line_pair_merge (
	// Bit 0 of the requested line, high when the fetch starts in an odd line
	input logic odd_first_i,

	// Bank results
	input logic even_hit_i,
	input icache_pkg::line_data_t even_data_i,
	input logic odd_hit_i,
	input icache_pkg::line_data_t odd_data_i,

	// Requested line number, registered alongside the bank lookups
	input icache_pkg::line_num_t req_line_i,

	// Ordered line pair
	output icache_pkg::line_data_t lo_line_o,
	output icache_pkg::line_data_t hi_line_o,
	output logic lo_hit_o,
	output logic hi_hit_o,
	output logic hit_o,
	output cpu_addr_pkg::fetch_addr_t miss_addr_o
);

	localparam int unsigned offset_bits = icache_pkg::offset_bits;

	icache_pkg::line_num_t hi_line_num;

	// ====================
	// Line ordering
	// ====================

	// Even first means the even bank holds L and the odd bank L+1
	// Odd first swaps them, the even bank was asked for L+1
	always_comb begin
		if (odd_first_i) begin
			lo_line_o = odd_data_i;
			lo_hit_o = odd_hit_i;
			hi_line_o = even_data_i;
			hi_hit_o = even_hit_i;
		end else begin
			lo_line_o = even_data_i;
			lo_hit_o = even_hit_i;
			hi_line_o = odd_data_i;
			hi_hit_o = odd_hit_i;
		end
	end

	// A group may cross into the next line, so both must be present
	assign hit_o = lo_hit_o && hi_hit_o;

	// ====================
	// Miss address
	// ====================

	assign hi_line_num = req_line_i + 1'b1;

	// Low line is fetched first when both miss
	always_comb begin
		if (!lo_hit_o) begin
			miss_addr_o = {req_line_i, {offset_bits{1'b0}}};
		end else if (!hi_hit_o) begin
			miss_addr_o = {hi_line_num, {offset_bits{1'b0}}};
		end else begin
			// No miss outstanding
			miss_addr_o = '1;
		end
	end

endmodule

// File: source/icache_top.sv
`timescale 1ns/100ps

module icache_top (
	input logic clk,
	input logic rst,

	// Fetch request, one per cycle at most
	input logic fetch_v_i,
	input cpu_addr_pkg::fetch_addr_t fetch_addr_i,

	// Refill from the miss handler
	input logic refill_v_i,
	input cpu_addr_pkg::fetch_addr_t refill_addr_i,
	input icache_pkg::way_t refill_way_i,
	input icache_pkg::line_data_t refill_data_i,

	// Invalidation
	input logic inval_line_i,
	input cpu_addr_pkg::fetch_addr_t inval_addr_i,
	input logic inval_all_i,

	// Snoop
	input logic snoop_v_i,
	input cpu_addr_pkg::fetch_addr_t snoop_addr_i,

	// Result, valid for one cycle, no back-pressure
	output logic result_v_o,
	output icache_pkg::line_data_t lo_line_o,
	output icache_pkg::line_data_t hi_line_o,
	output logic hit_o,
	output logic lo_hit_o,
	output logic hi_hit_o,
	output cpu_addr_pkg::fetch_addr_t miss_addr_o
);

	localparam int unsigned offset_bits = icache_pkg::offset_bits;
	localparam int unsigned index_bits = icache_pkg::index_bits;
	localparam int unsigned bank_sel_bit = icache_pkg::bank_sel_bit;
	localparam int unsigned line_w = $bits(icache_pkg::line_num_t);

	// Index sits just above the bank select bit of the line number
	function automatic icache_pkg::index_t line_index(input icache_pkg::line_num_t line);
		return line[index_bits:1];
	endfunction

	function automatic icache_pkg::tag_t line_tag(input icache_pkg::line_num_t line);
		return line[line_w-1:index_bits+1];
	endfunction

	icache_pkg::line_num_t fetch_line, even_line, odd_line;
	icache_pkg::line_num_t refill_line, inval_line, snoop_line;
	icache_pkg::line_num_t req_line_q;
	logic odd_first_q;
	logic result_v_q;
	logic even_hit, odd_hit;
	icache_pkg::line_data_t even_data, odd_data;

	// ====================
	// Line numbers
	// ====================

	assign fetch_line = fetch_addr_i[cpu_addr_pkg::addr_w-1:offset_bits];
	assign refill_line = refill_addr_i[cpu_addr_pkg::addr_w-1:offset_bits];
	assign inval_line = inval_addr_i[cpu_addr_pkg::addr_w-1:offset_bits];
	assign snoop_line = snoop_addr_i[cpu_addr_pkg::addr_w-1:offset_bits];

	// Even bank gets the even line at or after L, carry reaches the tag
	assign even_line = fetch_line + fetch_line[0];
	assign odd_line = fetch_line | icache_pkg::line_num_t'(1);

	// ====================
	// Result stage
	// ====================

	always_ff @(posedge clk) begin
		req_line_q <= fetch_line;
		odd_first_q <= fetch_line[0];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			result_v_q <= 1'b0;
		end else begin
			result_v_q <= fetch_v_i;
		end
	end

	assign result_v_o = result_v_q;

	// ====================
	// Banks
	// ====================

	icache_bank even_bank_inst (
		.clk(clk),
		.rst(rst),
		.req_index_i(line_index(even_line)),
		.req_tag_i(line_tag(even_line)),
		.wr_i(refill_v_i && !refill_addr_i[bank_sel_bit]),
		.wr_index_i(line_index(refill_line)),
		.wr_tag_i(line_tag(refill_line)),
		.wr_way_i(refill_way_i),
		.wr_data_i(refill_data_i),
		.inv_line_i(inval_line_i && !inval_addr_i[bank_sel_bit]),
		.inv_index_i(line_index(inval_line)),
		.inv_all_i(inval_all_i),
		.snoop_v_i(snoop_v_i && !snoop_addr_i[bank_sel_bit]),
		.snoop_index_i(line_index(snoop_line)),
		.snoop_tag_i(line_tag(snoop_line)),
		.hit_o(even_hit),
		.data_o(even_data)
	);

	icache_bank odd_bank_inst (
		.clk(clk),
		.rst(rst),
		.req_index_i(line_index(odd_line)),
		.req_tag_i(line_tag(odd_line)),
		.wr_i(refill_v_i && refill_addr_i[bank_sel_bit]),
		.wr_index_i(line_index(refill_line)),
		.wr_tag_i(line_tag(refill_line)),
		.wr_way_i(refill_way_i),
		.wr_data_i(refill_data_i),
		.inv_line_i(inval_line_i && inval_addr_i[bank_sel_bit]),
		.inv_index_i(line_index(inval_line)),
		.inv_all_i(inval_all_i),
		.snoop_v_i(snoop_v_i && snoop_addr_i[bank_sel_bit]),
		.snoop_index_i(line_index(snoop_line)),
		.snoop_tag_i(line_tag(snoop_line)),
		.hit_o(odd_hit),
		.data_o(odd_data)
	);

	line_pair_merge line_pair_merge_inst (
		.odd_first_i(odd_first_q),
		.even_hit_i(even_hit),
		.even_data_i(even_data),
		.odd_hit_i(odd_hit),
		.odd_data_i(odd_data),
		.req_line_i(req_line_q),
		.lo_line_o(lo_line_o),
		.hi_line_o(hi_line_o),
		.lo_hit_o(lo_hit_o),
		.hi_hit_o(hi_hit_o),
		.hit_o(hit_o),
		.miss_addr_o(miss_addr_o)
	);

	// A request caught during reset must not surface as a result
	a_no_result_after_rst: assert property (@(posedge clk) rst |=> !result_v_o);

endmodule

// File: tb/icache_tb.sv
`timescale 1ns/100ps

module icache_tb;

	localparam int unsigned result_timeout = 20;
	localparam int unsigned ways = icache_pkg::ways;
	localparam int unsigned sets = icache_pkg::sets;

	logic clk;
	logic rst;
	logic fetch_v;
	cpu_addr_pkg::fetch_addr_t fetch_addr;
	logic refill_v;
	cpu_addr_pkg::fetch_addr_t refill_addr;
	icache_pkg::way_t refill_way;
	icache_pkg::line_data_t refill_data;
	logic inval_line;
	cpu_addr_pkg::fetch_addr_t inval_addr;
	logic inval_all;
	logic snoop_v;
	cpu_addr_pkg::fetch_addr_t snoop_addr;
	logic result_v;
	icache_pkg::line_data_t lo_line;
	icache_pkg::line_data_t hi_line;
	logic hit;
	logic lo_hit;
	logic hi_hit;
	cpu_addr_pkg::fetch_addr_t miss_addr;

	int value_errors = 0;
	int other_errors = 0;

	// ====================
	// Reference model
	// ====================

	// Line contents by line number, plus which line each bank entry holds
	icache_pkg::line_data_t data_model [icache_pkg::line_num_t];
	icache_pkg::line_num_t way_line [2][ways][sets];
	bit way_valid [2][ways][sets];

	icache_top icache_top_inst (
		.clk(clk), .rst(rst),
		.fetch_v_i(fetch_v), .fetch_addr_i(fetch_addr),
		.refill_v_i(refill_v), .refill_addr_i(refill_addr),
		.refill_way_i(refill_way), .refill_data_i(refill_data),
		.inval_line_i(inval_line), .inval_addr_i(inval_addr), .inval_all_i(inval_all),
		.snoop_v_i(snoop_v), .snoop_addr_i(snoop_addr),
		.result_v_o(result_v), .lo_line_o(lo_line), .hi_line_o(hi_line),
		.hit_o(hit), .lo_hit_o(lo_hit), .hi_hit_o(hi_hit), .miss_addr_o(miss_addr)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Even lines go to bank 0, odd lines to bank 1
	function automatic int bank_of(input icache_pkg::line_num_t line);
		return int'(line[0]);
	endfunction

	// The set index sits right above the bank select bit
	function automatic int set_of(input icache_pkg::line_num_t line);
		return int'(line[icache_pkg::index_bits:1]);
	endfunction

	function automatic cpu_addr_pkg::fetch_addr_t line_addr(input icache_pkg::line_num_t line);
		return {line, {icache_pkg::offset_bits{1'b0}}};
	endfunction

	function automatic logic model_hit(input icache_pkg::line_num_t line);
		logic found;
		found = 1'b0;
		for (int w = 0; w < ways; w++) begin
			if (way_valid[bank_of(line)][w][set_of(line)] &&
					way_line[bank_of(line)][w][set_of(line)] == line) begin
				found = 1'b1;
			end
		end
		return found;
	endfunction

	function automatic icache_pkg::line_data_t rand_line();
		icache_pkg::line_data_t value;
		for (int i = 0; i < 8; i++) begin
			value[i*32 +: 32] = $urandom;
		end
		return value;
	endfunction

	// ====================
	// Compare tasks
	// ====================

	task automatic check_line(input string name, input icache_pkg::line_data_t expected,
			input icache_pkg::line_data_t actual);
		if (actual !== expected) begin
			value_errors++;
			$display("** Error: %s expected %h actual %h", name, expected, actual);
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			value_errors++;
			$display("** Error: %s expected %b actual %b", name, expected, actual);
		end
	endtask

	task automatic check_addr(input string name, input cpu_addr_pkg::fetch_addr_t expected,
			input cpu_addr_pkg::fetch_addr_t actual);
		if (actual !== expected) begin
			value_errors++;
			$display("** Error: %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// ====================
	// Drivers
	// ====================

	task automatic refill(input icache_pkg::line_num_t line, input icache_pkg::way_t way);
		icache_pkg::line_data_t value;
		value = rand_line();
		@(negedge clk);
		refill_v = 1'b1;
		refill_addr = line_addr(line);
		refill_way = way;
		refill_data = value;
		@(negedge clk);
		refill_v = 1'b0;
		data_model[line] = value;
		way_line[bank_of(line)][way][set_of(line)] = line;
		way_valid[bank_of(line)][way][set_of(line)] = 1'b1;
	endtask

	// Line invalidation clears the whole set in the bank that owns the line
	task automatic invalidate_line(input icache_pkg::line_num_t line);
		@(negedge clk);
		inval_line = 1'b1;
		inval_addr = line_addr(line);
		@(negedge clk);
		inval_line = 1'b0;
		for (int w = 0; w < ways; w++) begin
			way_valid[bank_of(line)][w][set_of(line)] = 1'b0;
		end
	endtask

	task automatic invalidate_all();
		@(negedge clk);
		inval_all = 1'b1;
		@(negedge clk);
		inval_all = 1'b0;
		for (int b = 0; b < 2; b++) begin
			for (int w = 0; w < ways; w++) begin
				for (int s = 0; s < sets; s++) begin
					way_valid[b][w][s] = 1'b0;
				end
			end
		end
	endtask

	// Tags are read on the first edge and valid bits cleared on the second
	task automatic snoop(input icache_pkg::line_num_t line);
		@(negedge clk);
		snoop_v = 1'b1;
		snoop_addr = line_addr(line);
		@(negedge clk);
		snoop_v = 1'b0;
		@(negedge clk);
		for (int w = 0; w < ways; w++) begin
			if (way_line[bank_of(line)][w][set_of(line)] == line) begin
				way_valid[bank_of(line)][w][set_of(line)] = 1'b0;
			end
		end
	endtask

	// Sends one fetch and checks the line pair against the model
	task automatic fetch_check(input string name, input cpu_addr_pkg::fetch_addr_t addr);
		icache_pkg::line_num_t lo;
		icache_pkg::line_num_t hi;
		logic lo_exp;
		logic hi_exp;
		cpu_addr_pkg::fetch_addr_t miss_exp;
		int waited;
		lo = addr[cpu_addr_pkg::addr_w-1:icache_pkg::offset_bits];
		hi = lo + icache_pkg::line_num_t'(1);
		lo_exp = model_hit(lo);
		hi_exp = model_hit(hi);
		if (!lo_exp) begin
			miss_exp = line_addr(lo);
		end else if (!hi_exp) begin
			miss_exp = line_addr(hi);
		end else begin
			miss_exp = '1;
		end
		@(negedge clk);
		// No fetch was taken at the last edge, so no result may show now
		check_bit({name, " result_v idle"}, 1'b0, result_v);
		fetch_v = 1'b1;
		fetch_addr = addr;
		waited = 0;
		do begin
			@(negedge clk);
			fetch_v = 1'b0;
			waited++;
		end while (!result_v && waited < result_timeout);
		if (!result_v) begin
			other_errors++;
			$display("%s: no fetch result came back within %0d cycles", name, result_timeout);
		end else begin
			// The result belongs in the cycle right after the request edge
			if (waited != 1) begin
				other_errors++;
				$display("%s: fetch result came after %0d cycles instead of one",
					name, waited);
			end
			check_bit({name, " hit"}, lo_exp && hi_exp, hit);
			check_bit({name, " lo_hit"}, lo_exp, lo_hit);
			check_bit({name, " hi_hit"}, hi_exp, hi_hit);
			check_addr({name, " miss_addr"}, miss_exp, miss_addr);
			// Line data only means something for a line that hit
			if (lo_exp) check_line({name, " lo_line"}, data_model[lo], lo_line);
			if (hi_exp) check_line({name, " hi_line"}, data_model[hi], hi_line);
		end
	endtask

	// ====================
	// Tests
	// ====================

	task automatic miss_after_reset();
		for (int i = 0; i < 4; i++) begin
			fetch_check("reset_miss", $urandom);
		end
	endtask

	task automatic line_pair_order();
		refill(27'h100, 1'b0);
		refill(27'h101, 1'b0);
		fetch_check("pair_even_first", line_addr(27'h100) + 32'd12);
		refill(27'h203, 1'b0);
		refill(27'h204, 1'b0);
		fetch_check("pair_odd_first", line_addr(27'h203) + 32'd28);
	endtask

	task automatic two_way_sets();
		// Same set in both banks, tags differ by one
		refill(27'h40A, 1'b0);
		refill(27'h44A, 1'b1);
		refill(27'h40B, 1'b1);
		refill(27'h44B, 1'b0);
		fetch_check("two_ways_a", line_addr(27'h40A) + 32'd4);
		fetch_check("two_ways_b", line_addr(27'h44A) + 32'd8);
		// Last odd line of the set range, the even partner needs the next tag
		refill(27'h7BF, 1'b0);
		refill(27'h7C0, 1'b1);
		fetch_check("tag_carry", line_addr(27'h7BF) + 32'd16);
	endtask

	task automatic partial_pair_hit();
		refill(27'h305, 1'b0);
		fetch_check("only_high", line_addr(27'h304) + 32'd2);
		refill(27'h50C, 1'b0);
		fetch_check("only_low", line_addr(27'h50C) + 32'd20);
	endtask

	task automatic line_and_all_invalidation();
		invalidate_line(27'h101);
		fetch_check("inval_line_gone", line_addr(27'h100));
		fetch_check("inval_line_other", line_addr(27'h203));
		fetch_check("inval_line_carry", line_addr(27'h7BF));
		invalidate_all();
		fetch_check("inval_all_a", line_addr(27'h203));
		fetch_check("inval_all_b", line_addr(27'h40A));
		fetch_check("inval_all_c", line_addr(27'h7BF));
	endtask

	task automatic snoop_invalidation();
		refill(27'h610, 1'b0);
		refill(27'h611, 1'b1);
		fetch_check("snoop_before", line_addr(27'h610));
		// Same set as 0x610 with another tag, nothing may change
		snoop(27'h650);
		fetch_check("snoop_uncached", line_addr(27'h610));
		snoop(27'h611);
		fetch_check("snoop_pair", line_addr(27'h610));
		fetch_check("snoop_line", line_addr(27'h611));
	endtask

	initial begin
		void'($urandom(40781));
		rst = 1'b1;
		fetch_v = 1'b0;
		fetch_addr = '0;
		refill_v = 1'b0;
		refill_addr = '0;
		refill_way = '0;
		refill_data = '0;
		inval_line = 1'b0;
		inval_addr = '0;
		inval_all = 1'b0;
		snoop_v = 1'b0;
		snoop_addr = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		miss_after_reset();
		line_pair_order();
		two_way_sets();
		partial_pair_hit();
		line_and_all_invalidation();
		snoop_invalidation();

		$display("Value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: list.f
source/cpu_addr_pkg.sv
source/icache_pkg.sv
source/line_ram.sv
source/icache_bank.sv
source/line_pair_merge.sv
source/icache_top.sv
tb/icache_tb.sv

// File: Makefile
# Verilator build and run for the instruction cache testbench

TOP := icache_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module $(TOP) -Mdir obj_dir

# The run passes only if the log holds the pass line
run: compile
	./obj_dir/V$(TOP) > run.log 2>&1; cat run.log
	grep -q "^Testbench passed$$" run.log

clean:
	rm -rf obj_dir run.log
